// ==== hw/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// datapath and address width
`define XLEN 32

// first fetch address after reset
`define RESET_VEC 32'h0000_0000

// architectural integer registers, x0 included
`define REG_NUM 32

`endif

// ==== hw/rv_pkg.sv ====
package rv_pkg;

    typedef enum logic [6:0] {
        OPC_OP     = 7'b0110011,
        OPC_OP_IMM = 7'b0010011,
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_BRANCH = 7'b1100011,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_SYSTEM = 7'b1110011
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef enum logic [2:0] {
        BR_NONE,
        BR_EQ,
        BR_NE,
        BR_LT,
        BR_GE,
        BR_LTU,
        BR_GEU
    } br_type_e;

    typedef enum logic [2:0] {
        WB_NONE,
        WB_ALU,
        WB_PC4,   // link address of jal/jalr
        WB_LOAD,
        WB_CSR
    } wb_sel_e;

    typedef enum logic {
        A_PC,
        A_RS1
    } a_sel_e;

    typedef enum logic [1:0] {
        B_RS2,
        B_IMM,
        B_ZERO
    } b_sel_e;

    // encoding matches funct3[1:0] of the csr instructions
    typedef enum logic [1:0] {
        CSR_NONE,
        CSR_WRITE,
        CSR_SET,
        CSR_CLEAR
    } csr_op_e;

    typedef enum logic [11:0] {
        CSR_MSTATUS = 12'h300,
        CSR_MTVEC   = 12'h305,
        CSR_MEPC    = 12'h341,
        CSR_MCAUSE  = 12'h342
    } csr_addr_e;

endpackage

// ==== hw/ctrl_if.sv ====
`timescale 1ns/1ps

interface ctrl_if import rv_pkg::*; ();

    alu_op_e    alu_op;        // alu function
    a_sel_e     a_sel;         // operand a source
    b_sel_e     b_sel;         // operand b source
    br_type_e   br_type;       // branch compare kind
    logic       mem_rd;        // load
    logic       mem_wr;        // store
    logic [1:0] mem_size;      // 0 byte, 1 half, 2 word
    logic       mem_unsigned;  // lbu/lhu
    csr_op_e    csr_op;
    logic       csr_use_imm;   // csrr*i forms
    logic       is_ecall;
    logic       is_mret;
    logic       rf_we;         // rd write, gated by run in the top
    wb_sel_e    wb_sel;
    logic       is_jal;
    logic       is_jalr;

    modport drv  (output alu_op, a_sel, b_sel, br_type, mem_rd, mem_wr, mem_size,
                  mem_unsigned, csr_op, csr_use_imm, is_ecall, is_mret, rf_we,
                  wb_sel, is_jal, is_jalr);
    modport exe  (input alu_op, a_sel, b_sel, br_type);
    modport mem  (input mem_rd, mem_wr, mem_size, mem_unsigned);
    modport csr  (input csr_op, csr_use_imm, is_ecall, is_mret);
    modport core (input rf_we, wb_sel, is_jal, is_jalr, is_ecall, is_mret);

endinterface

// ==== hw/inst_decoder.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module inst_decoder import rv_pkg::*;
(
    input  logic [`XLEN-1:0] inst,
    ctrl_if.drv              ctrl
);

    opcode_e    opcode;
    logic [2:0] funct3;
    logic       alt;     // inst[30], sub/sra select

    assign opcode = opcode_e'(inst[6:0]);
    assign funct3 = inst[14:12];
    assign alt    = inst[30];

    // funct3 to alu function, shared by OP and OP_IMM
    function automatic alu_op_e alu_fn(input logic [2:0] f3, input logic sub_sra);
        case (f3)
            3'b000:  alu_fn = sub_sra ? ALU_SUB : ALU_ADD;
            3'b001:  alu_fn = ALU_SLL;
            3'b010:  alu_fn = ALU_SLT;
            3'b011:  alu_fn = ALU_SLTU;
            3'b100:  alu_fn = ALU_XOR;
            3'b101:  alu_fn = sub_sra ? ALU_SRA : ALU_SRL;
            3'b110:  alu_fn = ALU_OR;
            default: alu_fn = ALU_AND;
        endcase
    endfunction

    always_comb
    begin
        ctrl.alu_op       = ALU_ADD;   // inactive bundle, retires as nop
        ctrl.a_sel        = A_RS1;
        ctrl.b_sel        = B_ZERO;
        ctrl.br_type      = BR_NONE;
        ctrl.mem_rd       = 1'b0;
        ctrl.mem_wr       = 1'b0;
        ctrl.mem_size     = funct3[1:0];
        ctrl.mem_unsigned = funct3[2];
        ctrl.csr_op       = CSR_NONE;
        ctrl.csr_use_imm  = funct3[2];
        ctrl.is_ecall     = 1'b0;
        ctrl.is_mret      = 1'b0;
        ctrl.rf_we        = 1'b0;
        ctrl.wb_sel       = WB_NONE;
        ctrl.is_jal       = 1'b0;
        ctrl.is_jalr      = 1'b0;
        case (opcode)
            OPC_OP:
            begin
                ctrl.alu_op = alu_fn(funct3, alt);
                ctrl.b_sel  = B_RS2;
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_ALU;
            end
            OPC_OP_IMM:
            begin
                ctrl.alu_op = alu_fn(funct3, alt && funct3 == 3'b101);  // addi has no sub
                ctrl.b_sel  = B_IMM;
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_ALU;
            end
            OPC_LOAD:
            begin
                ctrl.b_sel  = B_IMM;    // rs1 + offset
                ctrl.mem_rd = 1'b1;
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_LOAD;
            end
            OPC_STORE:
            begin
                ctrl.b_sel  = B_IMM;
                ctrl.mem_wr = 1'b1;
            end
            OPC_BRANCH:
            begin
                ctrl.a_sel = A_PC;      // alu forms the target
                ctrl.b_sel = B_IMM;
                case (funct3)
                    3'b000:  ctrl.br_type = BR_EQ;
                    3'b001:  ctrl.br_type = BR_NE;
                    3'b100:  ctrl.br_type = BR_LT;
                    3'b101:  ctrl.br_type = BR_GE;
                    3'b110:  ctrl.br_type = BR_LTU;
                    3'b111:  ctrl.br_type = BR_GEU;
                    default: ctrl.br_type = BR_NONE;
                endcase
            end
            OPC_JAL, OPC_JALR:
            begin
                ctrl.a_sel   = (opcode == OPC_JAL) ? A_PC : A_RS1;
                ctrl.b_sel   = B_IMM;
                ctrl.rf_we   = 1'b1;
                ctrl.wb_sel  = WB_PC4;
                ctrl.is_jal  = (opcode == OPC_JAL);
                ctrl.is_jalr = (opcode == OPC_JALR);
            end
            OPC_LUI, OPC_AUIPC:
            begin
                ctrl.alu_op = (opcode == OPC_LUI) ? ALU_PASS_B : ALU_ADD;
                ctrl.a_sel  = A_PC;
                ctrl.b_sel  = B_IMM;
                ctrl.rf_we  = 1'b1;
                ctrl.wb_sel = WB_ALU;
            end
            OPC_SYSTEM:
            begin
                if (funct3 == 3'b000)
                begin
                    ctrl.is_ecall = (inst[31:20] == 12'h000);
                    ctrl.is_mret  = (inst[31:20] == 12'h302);
                end
                else
                begin
                    ctrl.csr_op = csr_op_e'(funct3[1:0]);
                    ctrl.rf_we  = 1'b1;      // rd gets the old csr value
                    ctrl.wb_sel = WB_CSR;
                end
            end
            default:
            begin
                ctrl.rf_we = 1'b0;  // unknown opcode
            end
        endcase
    end

endmodule

// ==== hw/imm_gen.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module imm_gen import rv_pkg::*;
(
    input  logic [`XLEN-1:0] inst,
    output logic [`XLEN-1:0] imm
);

    opcode_e opcode;

    assign opcode = opcode_e'(inst[6:0]);

    always_comb
    begin
        case (opcode)
            OPC_STORE:               // s-type
                imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
            OPC_BRANCH:              // b-type, bit 0 always zero
                imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
            OPC_LUI, OPC_AUIPC:      // u-type fills upper 20 bits
                imm = {inst[31:12], 12'b0};
            OPC_JAL:                 // j-type
                imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
            default:                 // i-type
                imm = {{20{inst[31]}}, inst[31:20]};
        endcase
    end

endmodule

// ==== hw/exec_unit.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module exec_unit import rv_pkg::*;
(
    ctrl_if.exe              ctrl,
    input  logic [`XLEN-1:0] pc,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [`XLEN-1:0] rs2_data,
    input  logic [`XLEN-1:0] imm,
    output logic [`XLEN-1:0] alu_out,
    output logic             br_taken
);

    logic [`XLEN-1:0] op_a;
    logic [`XLEN-1:0] op_b;
    logic [4:0]       shamt;

    assign op_a  = (ctrl.a_sel == A_PC) ? pc : rs1_data;
    assign shamt = op_b[4:0];   // rv32 shifts use 5 bits

    always_comb
    begin
        case (ctrl.b_sel)
            B_RS2:   op_b = rs2_data;
            B_IMM:   op_b = imm;
            default: op_b = '0;
        endcase
    end

    always_comb
    begin
        case (ctrl.alu_op)
            ALU_ADD:    alu_out = op_a + op_b;
            ALU_SUB:    alu_out = op_a - op_b;
            ALU_SLL:    alu_out = op_a << shamt;
            ALU_SLT:    alu_out = {31'b0, $signed(op_a) < $signed(op_b)};
            ALU_SLTU:   alu_out = {31'b0, op_a < op_b};
            ALU_XOR:    alu_out = op_a ^ op_b;
            ALU_SRL:    alu_out = op_a >> shamt;
            ALU_SRA:    alu_out = $unsigned($signed(op_a) >>> shamt);
            ALU_OR:     alu_out = op_a | op_b;
            ALU_AND:    alu_out = op_a & op_b;
            ALU_PASS_B: alu_out = op_b;
            default:    alu_out = '0;
        endcase
    end

    // branch compare always on rs1/rs2, independent of the alu operands
    always_comb
    begin
        case (ctrl.br_type)
            BR_EQ:   br_taken = (rs1_data == rs2_data);
            BR_NE:   br_taken = (rs1_data != rs2_data);
            BR_LT:   br_taken = ($signed(rs1_data) < $signed(rs2_data));
            BR_GE:   br_taken = ($signed(rs1_data) >= $signed(rs2_data));
            BR_LTU:  br_taken = (rs1_data < rs2_data);
            BR_GEU:  br_taken = (rs1_data >= rs2_data);
            default: br_taken = 1'b0;
        endcase
    end

endmodule

// ==== hw/reg_file.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module reg_file
(
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic [$clog2(`REG_NUM)-1:0] rs1_addr,
    input  logic [$clog2(`REG_NUM)-1:0] rs2_addr,
    input  logic [$clog2(`REG_NUM)-1:0] rd_addr,
    input  logic                         rd_we,
    input  logic [`XLEN-1:0]            rd_data,
    output logic [`XLEN-1:0]            rs1_data,
    output logic [`XLEN-1:0]            rs2_data
);

    logic [`XLEN-1:0] regs [1:`REG_NUM-1];  // no storage for x0

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            for (int i = 1; i < `REG_NUM; i++)
                regs[i] <= '0;
        end
        else if (rd_we && rd_addr != '0)   // x0 writes dropped
        begin
            regs[rd_addr] <= rd_data;
        end
    end

    // combinational read, new value shows next cycle
    assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
    assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

// ==== hw/csr_unit.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module csr_unit import rv_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    ctrl_if.csr              ctrl,
    input  logic             run,
    input  logic [11:0]      csr_addr,
    input  logic [`XLEN-1:0] rs1_data,
    input  logic [4:0]       zimm,       // rs1 field of csrr*i
    input  logic [`XLEN-1:0] pc,
    output logic [`XLEN-1:0] csr_rdata,
    output logic [`XLEN-1:0] trap_vec,
    output logic [`XLEN-1:0] ret_pc
);

    logic [`XLEN-1:0] mstatus;
    logic [`XLEN-1:0] mtvec;
    logic [`XLEN-1:0] mepc;
    logic [`XLEN-1:0] mcause;
    logic [`XLEN-1:0] wr_src;
    logic [`XLEN-1:0] wr_val;

    assign wr_src = ctrl.csr_use_imm ? {{(`XLEN-5){1'b0}}, zimm} : rs1_data;

    always_comb
    begin
        case (csr_addr_e'(csr_addr))
            CSR_MSTATUS: csr_rdata = mstatus;
            CSR_MTVEC:   csr_rdata = mtvec;
            CSR_MEPC:    csr_rdata = mepc;
            CSR_MCAUSE:  csr_rdata = mcause;
            default:     csr_rdata = '0;   // unimplemented reads zero
        endcase
    end

    always_comb
    begin
        case (ctrl.csr_op)
            CSR_WRITE: wr_val = wr_src;
            CSR_SET:   wr_val = csr_rdata | wr_src;
            CSR_CLEAR: wr_val = csr_rdata & ~wr_src;
            default:   wr_val = csr_rdata;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            mstatus <= 32'h0000_1800;   // mpp = machine
            mtvec   <= '0;
            mepc    <= '0;
            mcause  <= '0;
        end
        else if (run)
        begin
            if (ctrl.is_ecall)
            begin
                mepc       <= pc;
                mcause     <= 32'd11;        // ecall from m-mode
                mstatus[7] <= mstatus[3];    // mpie <= mie
                mstatus[3] <= 1'b0;
            end
            else if (ctrl.is_mret)
            begin
                mstatus[3] <= mstatus[7];    // mie <= mpie
                mstatus[7] <= 1'b1;
            end
            else if (ctrl.csr_op != CSR_NONE)
            begin
                case (csr_addr_e'(csr_addr))
                    CSR_MSTATUS: mstatus <= wr_val;
                    CSR_MTVEC:   mtvec   <= wr_val;
                    CSR_MEPC:    mepc    <= {wr_val[`XLEN-1:2], 2'b00};
                    CSR_MCAUSE:  mcause  <= wr_val;
                    default:     mcause  <= mcause;
                endcase
            end
        end
    end

    assign trap_vec = {mtvec[`XLEN-1:2], 2'b00};  // direct mode only
    assign ret_pc   = mepc;

endmodule

// ==== hw/lsu.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module lsu
(
    ctrl_if.mem              ctrl,
    input  logic             run,
    input  logic [`XLEN-1:0] addr,
    input  logic [`XLEN-1:0] store_data,
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic [`XLEN-1:0] dmem_addr,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic [3:0]       dmem_wstrb,
    output logic             dmem_we,
    output logic [`XLEN-1:0] load_data
);

    logic [1:0]  ofs;       // byte offset in word
    logic [7:0]  ld_byte;
    logic [15:0] ld_half;

    assign ofs       = addr[1:0];
    assign dmem_addr = {addr[`XLEN-1:2], 2'b00};
    assign dmem_we   = run & ctrl.mem_wr;

    always_comb
    begin
        case (ctrl.mem_size)
            2'b00:
            begin
                dmem_wdata = {4{store_data[7:0]}};     // byte on every lane
                dmem_wstrb = 4'b0001 << ofs;
            end
            2'b01:
            begin
                dmem_wdata = {2{store_data[15:0]}};
                dmem_wstrb = 4'b0011 << {ofs[1], 1'b0};
            end
            default:
            begin
                dmem_wdata = store_data;
                dmem_wstrb = 4'b1111;
            end
        endcase
        if (!ctrl.mem_wr)
            dmem_wstrb = 4'b0000;
    end

    assign ld_byte = dmem_rdata[{ofs, 3'b000} +: 8];
    assign ld_half = dmem_rdata[{ofs[1], 4'b0000} +: 16];

    always_comb
    begin
        if (!ctrl.mem_rd)
            load_data = '0;
        else if (ctrl.mem_size == 2'b00)
            load_data = {{24{~ctrl.mem_unsigned & ld_byte[7]}}, ld_byte};
        else if (ctrl.mem_size == 2'b01)
            load_data = {{16{~ctrl.mem_unsigned & ld_half[15]}}, ld_half};
        else
            load_data = dmem_rdata;
    end

endmodule

// ==== hw/rv_core.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module rv_core import rv_pkg::*;
(
    input  logic             clk,
    input  logic             arst_n,
    output logic [`XLEN-1:0] imem_addr,
    input  logic [`XLEN-1:0] imem_data,
    output logic [`XLEN-1:0] dmem_addr,
    input  logic [`XLEN-1:0] dmem_rdata,
    output logic [`XLEN-1:0] dmem_wdata,
    output logic [3:0]       dmem_wstrb,
    output logic             dmem_we
);

    logic [`XLEN-1:0] pc;
    logic [`XLEN-1:0] pc_next;
    logic [`XLEN-1:0] pc_plus4;
    logic [`XLEN-1:0] imm;
    logic [`XLEN-1:0] rs1_data;
    logic [`XLEN-1:0] rs2_data;
    logic [`XLEN-1:0] alu_out;
    logic [`XLEN-1:0] load_data;
    logic [`XLEN-1:0] csr_rdata;
    logic [`XLEN-1:0] trap_vec;
    logic [`XLEN-1:0] ret_pc;
    logic [`XLEN-1:0] wb_data;
    logic             run;        // clear for one cycle after reset release
    logic             br_taken;

    ctrl_if ctrl ();

    inst_decoder u_dec (.inst(imem_data), .ctrl(ctrl.drv));
    imm_gen      u_imm (.inst(imem_data), .imm(imm));

    reg_file u_rf (
        .clk      (clk),
        .arst_n   (arst_n),
        .rs1_addr (imem_data[19:15]),
        .rs2_addr (imem_data[24:20]),
        .rd_addr  (imem_data[11:7]),
        .rd_we    (ctrl.rf_we & run),
        .rd_data  (wb_data),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data)
    );

    exec_unit u_exe (
        .ctrl     (ctrl.exe),
        .pc       (pc),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .imm      (imm),
        .alu_out  (alu_out),
        .br_taken (br_taken)
    );

    lsu u_lsu (
        .ctrl       (ctrl.mem),
        .run        (run),
        .addr       (alu_out),      // rs1 + offset
        .store_data (rs2_data),
        .dmem_rdata (dmem_rdata),
        .dmem_addr  (dmem_addr),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .dmem_we    (dmem_we),
        .load_data  (load_data)
    );

    csr_unit u_csr (
        .clk       (clk),
        .arst_n    (arst_n),
        .ctrl      (ctrl.csr),
        .run       (run),
        .csr_addr  (imem_data[31:20]),
        .rs1_data  (rs1_data),
        .zimm      (imem_data[19:15]),
        .pc        (pc),
        .csr_rdata (csr_rdata),
        .trap_vec  (trap_vec),
        .ret_pc    (ret_pc)
    );

    assign imem_addr = pc;
    assign pc_plus4  = pc + 32'd4;

    // trap first, then return, then jumps and taken branches
    always_comb
    begin
        if (ctrl.is_ecall)
            pc_next = trap_vec;
        else if (ctrl.is_mret)
            pc_next = ret_pc;
        else if (ctrl.is_jalr)
            pc_next = {alu_out[`XLEN-1:1], 1'b0};   // low bit cleared
        else if (ctrl.is_jal || br_taken)
            pc_next = alu_out;
        else
            pc_next = pc_plus4;
    end

    always_comb
    begin
        case (ctrl.wb_sel)
            WB_ALU:  wb_data = alu_out;
            WB_PC4:  wb_data = pc_plus4;
            WB_LOAD: wb_data = load_data;
            WB_CSR:  wb_data = csr_rdata;   // old csr value
            default: wb_data = '0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc  <= `RESET_VEC;
            run <= 1'b0;
        end
        else
        begin
            run <= 1'b1;
            if (run)
                pc <= pc_next;   // one retire per edge
        end
    end

endmodule

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`include "rv_defs.svh"

module tb_rv_core;

    localparam int RST_CYCLES = 4;
    localparam int RST_LIMIT  = 8;      // cycles allowed for the reset phase
    localparam int RUN_LIMIT  = 200;    // cycles allowed for the whole table

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] inst;
        logic        we;       // store expected this cycle
        logic [31:0] addr;     // word address of the store
        logic [3:0]  strb;
        logic [31:0] data;     // store bytes already in their lanes
        logic [31:0] npc;
    } row_t;

    logic             clk;
    logic             arst_n;
    logic [`XLEN-1:0] imem_addr;
    logic [`XLEN-1:0] imem_data;
    logic [`XLEN-1:0] dmem_addr;
    logic [`XLEN-1:0] dmem_rdata;
    logic [`XLEN-1:0] dmem_wdata;
    logic [3:0]       dmem_wstrb;
    logic             dmem_we;

    logic [31:0] rom [0:255];
    logic [31:0] ram [0:255];
    row_t        rows [$];     // execution order

    rv_core u_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .imem_addr  (imem_addr),
        .imem_data  (imem_data),
        .dmem_addr  (dmem_addr),
        .dmem_rdata (dmem_rdata),
        .dmem_wdata (dmem_wdata),
        .dmem_wstrb (dmem_wstrb),
        .dmem_we    (dmem_we)
    );

    always #2 clk = ~clk;   // 4 ns period

    assign imem_data  = rom[imem_addr[9:2]];   // same-cycle reads
    assign dmem_rdata = ram[dmem_addr[9:2]];

    // data ram, byte writes on the rising edge
    always @(posedge clk)
    begin
        if (dmem_we)
        begin
            for (int b = 0; b < 4; b++)
                if (dmem_wstrb[b])
                    ram[dmem_addr[9:2]][8*b +: 8] <= dmem_wdata[8*b +: 8];
        end
    end

    // instruction formats
    function automatic logic [31:0] r_type(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3, input logic [4:0] rd);
        return {f7, rs2, rs1, f3, rd, 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] f3, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] s_type(input logic [11:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [12:0] imm, input logic [4:0] rs2, rs1,
                                           input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [19:0] imm, input logic [4:0] rd,
                                           input logic [6:0] op);
        return {imm, rd, op};
    endfunction

    function automatic logic [31:0] j_type(input logic [20:0] imm, input logic [4:0] rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'h6f};
    endfunction

    task automatic stop_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        if (act !== exp)
            stop_run($sformatf("Mismatch at %0t: %s expected %h, got %h",
                               $time, name, exp, act));
    endtask

    task automatic instr_row(input logic [31:0] pc, inst, npc);
        rows.push_back('{pc: pc, inst: inst, we: 1'b0, addr: '0, strb: '0, data: '0, npc: npc});
    endtask

    task automatic store_row(input logic [31:0] pc, inst, addr, input logic [3:0] strb,
                             input logic [31:0] data);
        rows.push_back('{pc: pc, inst: inst, we: 1'b1, addr: addr, strb: strb, data: data,
                         npc: pc + 32'd4});
    endtask

    task automatic load_program();
        instr_row(32'h00, i_type(12'd100, 5'd0, 3'd0, 5'd1, 7'h13), 32'h04);    // x1 = 100
        instr_row(32'h04, i_type(12'hff9, 5'd0, 3'd0, 5'd2, 7'h13), 32'h08);    // x2 = -7
        instr_row(32'h08, r_type(7'h00, 5'd2, 5'd1, 3'd0, 5'd3), 32'h0c);       // add, 93
        instr_row(32'h0c, r_type(7'h20, 5'd1, 5'd2, 3'd0, 5'd4), 32'h10);       // sub, -107
        instr_row(32'h10, r_type(7'h00, 5'd1, 5'd2, 3'd2, 5'd5), 32'h14);       // slt, 1
        instr_row(32'h14, i_type(12'h004, 5'd1, 3'd1, 5'd6, 7'h13), 32'h18);    // slli 4
        instr_row(32'h18, i_type(12'h401, 5'd2, 3'd5, 5'd7, 7'h13), 32'h1c);    // srai 1
        instr_row(32'h1c, u_type(20'h12345, 5'd9, 7'h37), 32'h20);              // lui
        instr_row(32'h20, u_type(20'h00001, 5'd10, 7'h17), 32'h24);             // auipc
        instr_row(32'h24, i_type(12'd5, 5'd1, 3'd0, 5'd0, 7'h13), 32'h28);      // x0 target
        store_row(32'h28, s_type(12'h200, 5'd3, 5'd0, 3'd2), 32'h200, 4'hf, 32'h0000_005d);
        store_row(32'h2c, s_type(12'h204, 5'd4, 5'd0, 3'd2), 32'h204, 4'hf, 32'hffff_ff95);
        store_row(32'h30, s_type(12'h208, 5'd5, 5'd0, 3'd2), 32'h208, 4'hf, 32'h0000_0001);
        store_row(32'h34, s_type(12'h20c, 5'd6, 5'd0, 3'd2), 32'h20c, 4'hf, 32'h0000_0640);
        store_row(32'h38, s_type(12'h210, 5'd7, 5'd0, 3'd2), 32'h210, 4'hf, 32'hffff_fffc);
        store_row(32'h3c, s_type(12'h214, 5'd9, 5'd0, 3'd2), 32'h214, 4'hf, 32'h1234_5000);
        store_row(32'h40, s_type(12'h218, 5'd10, 5'd0, 3'd2), 32'h218, 4'hf, 32'h0000_1020);
        store_row(32'h44, s_type(12'h21c, 5'd0, 5'd0, 3'd2), 32'h21c, 4'hf, 32'h0000_0000);
        instr_row(32'h48, b_type(13'd8, 5'd1, 5'd1, 3'd0), 32'h50);   // beq taken
        instr_row(32'h50, b_type(13'd8, 5'd2, 5'd1, 3'd0), 32'h54);   // beq not taken
        instr_row(32'h54, b_type(13'd8, 5'd1, 5'd2, 3'd4), 32'h5c);   // blt -7 < 100
        instr_row(32'h5c, b_type(13'd8, 5'd2, 5'd1, 3'd4), 32'h60);
        instr_row(32'h60, b_type(13'd8, 5'd1, 5'd2, 3'd7), 32'h68);   // bgeu, big unsigned
        instr_row(32'h68, b_type(13'd8, 5'd2, 5'd1, 3'd7), 32'h6c);
        instr_row(32'h6c, j_type(21'd12, 5'd11), 32'h78);                        // link 0x70
        instr_row(32'h78, i_type(12'h090, 5'd0, 3'd0, 5'd12, 7'h13), 32'h7c);
        instr_row(32'h7c, i_type(12'd1, 5'd12, 3'd0, 5'd13, 7'h67), 32'h90);    // odd target
        store_row(32'h90, s_type(12'h220, 5'd11, 5'd0, 3'd2), 32'h220, 4'hf, 32'h0000_0070);
        store_row(32'h94, s_type(12'h224, 5'd13, 5'd0, 3'd2), 32'h224, 4'hf, 32'h0000_0080);
        instr_row(32'h98, u_type(20'h89abd, 5'd14, 7'h37), 32'h9c);
        instr_row(32'h9c, i_type(12'hdef, 5'd14, 3'd0, 5'd14, 7'h13), 32'ha0);  // 0x89abcdef
        // byte and half stores, word 0x240 ends as efF964ef
        store_row(32'ha0, s_type(12'h240, 5'd14, 5'd0, 3'd0), 32'h240, 4'h1, 32'h0000_00ef);
        store_row(32'ha4, s_type(12'h241, 5'd1, 5'd0, 3'd0), 32'h240, 4'h2, 32'h0000_6400);
        store_row(32'ha8, s_type(12'h242, 5'd2, 5'd0, 3'd0), 32'h240, 4'h4, 32'h00f9_0000);
        store_row(32'hac, s_type(12'h243, 5'd14, 5'd0, 3'd0), 32'h240, 4'h8, 32'hef00_0000);
        store_row(32'hb0, s_type(12'h244, 5'd14, 5'd0, 3'd1), 32'h244, 4'h3, 32'h0000_cdef);
        store_row(32'hb4, s_type(12'h246, 5'd2, 5'd0, 3'd1), 32'h244, 4'hc, 32'hfff9_0000);
        instr_row(32'hb8, i_type(12'h242, 5'd0, 3'd0, 5'd15, 7'h03), 32'hbc);   // lb
        instr_row(32'hbc, i_type(12'h243, 5'd0, 3'd4, 5'd16, 7'h03), 32'hc0);   // lbu
        instr_row(32'hc0, i_type(12'h244, 5'd0, 3'd1, 5'd17, 7'h03), 32'hc4);   // lh
        instr_row(32'hc4, i_type(12'h240, 5'd0, 3'd2, 5'd18, 7'h03), 32'hc8);   // lw
        store_row(32'hc8, s_type(12'h250, 5'd15, 5'd0, 3'd2), 32'h250, 4'hf, 32'hffff_fff9);
        store_row(32'hcc, s_type(12'h254, 5'd16, 5'd0, 3'd2), 32'h254, 4'hf, 32'h0000_00ef);
        store_row(32'hd0, s_type(12'h258, 5'd17, 5'd0, 3'd2), 32'h258, 4'hf, 32'hffff_cdef);
        store_row(32'hd4, s_type(12'h25c, 5'd18, 5'd0, 3'd2), 32'h25c, 4'hf, 32'heff9_64ef);
        instr_row(32'hd8, i_type(12'h140, 5'd0, 3'd0, 5'd21, 7'h13), 32'hdc);   // handler
        instr_row(32'hdc, i_type(12'h305, 5'd21, 3'd1, 5'd0, 7'h73), 32'he0);   // mtvec
        instr_row(32'he0, 32'h0000_0073, 32'h140);                               // ecall
        instr_row(32'h140, i_type(12'h341, 5'd0, 3'd2, 5'd22, 7'h73), 32'h144); // read mepc
        instr_row(32'h144, i_type(12'h342, 5'd0, 3'd2, 5'd23, 7'h73), 32'h148); // read mcause
        store_row(32'h148, s_type(12'h270, 5'd22, 5'd0, 3'd2), 32'h270, 4'hf, 32'h0000_00e0);
        store_row(32'h14c, s_type(12'h274, 5'd23, 5'd0, 3'd2), 32'h274, 4'hf, 32'h0000_000b);
        instr_row(32'h150, i_type(12'd4, 5'd22, 3'd0, 5'd22, 7'h13), 32'h154);  // skip ecall
        instr_row(32'h154, i_type(12'h341, 5'd22, 3'd1, 5'd0, 7'h73), 32'h158);
        instr_row(32'h158, 32'h3020_0073, 32'he4);                               // mret
        instr_row(32'he4, j_type(21'd0, 5'd0), 32'he4);                          // park
    endtask

    initial
    begin
        int          cyc;
        int          idx;
        logic [31:0] mask;
        clk    = 1'b0;
        arst_n = 1'b0;
        for (int i = 0; i < 256; i++)
        begin
            rom[i] = 32'h0;                                  // unknown opcode, no-op
            ram[i] = {8'hc3, i[7:0], ~i[7:0], i[7:0]};       // index-based background
        end
        load_program();
        foreach (rows[k])
            rom[rows[k].pc[9:2]] = rows[k].inst;

        cyc = 0;
        while (arst_n !== 1'b1)
        begin
            @(negedge clk);
            cyc++;
            check_eq("imem_addr", `RESET_VEC, imem_addr);
            check_eq("dmem_we", 32'h0, 32'(dmem_we));
            if (cyc == RST_CYCLES)
                arst_n = 1'b1;                               // release on the falling edge
            else if (cyc > RST_LIMIT)
                stop_run("Reset phase did not end within its cycle limit");
        end
        check_eq("imem_addr", `RESET_VEC, imem_addr);        // run still clear here
        check_eq("dmem_we", 32'h0, 32'(dmem_we));

        idx = 0;
        cyc = 0;
        while (idx < rows.size())
        begin
            @(negedge clk);
            cyc++;
            if (cyc > RUN_LIMIT)
                stop_run("Program did not reach the last table row in time");
            if (idx > 0)
                check_eq("next pc", rows[idx-1].npc, imem_addr);
            check_eq("imem_addr", rows[idx].pc, imem_addr);
            check_eq("dmem_we", 32'(rows[idx].we), 32'(dmem_we));
            if (rows[idx].we)
            begin
                mask = {{8{rows[idx].strb[3]}}, {8{rows[idx].strb[2]}},
                        {8{rows[idx].strb[1]}}, {8{rows[idx].strb[0]}}};
                check_eq("dmem_addr", rows[idx].addr, dmem_addr);
                check_eq("dmem_wstrb", 32'(rows[idx].strb), 32'(dmem_wstrb));
                check_eq("dmem_wdata", rows[idx].data & mask, dmem_wdata & mask);
            end
            idx++;
        end
        @(negedge clk);
        check_eq("next pc", rows[idx-1].npc, imem_addr);    // park loop holds its pc
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== verilog.f ====
+incdir+hw
hw/rv_pkg.sv
hw/ctrl_if.sv
hw/inst_decoder.sv
hw/imm_gen.sv
hw/exec_unit.sv
hw/reg_file.sv
hw/csr_unit.sv
hw/lsu.sv
hw/rv_core.sv
tb/tb_rv_core.sv

// ==== Makefile ====
TOOL  = verilator
FLAGS = --binary --timing --timescale 1ns/1ps
TOP   = tb_rv_core
FLIST = verilog.f
OBJ   = obj_dir
LOG   = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	./$(OBJ)/V$(TOP) | tee $(LOG)
	grep -q "^TEST RESULT: PASS$$" $(LOG)

lint:
	$(TOOL) --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(OBJ) $(LOG)
